//--- verilog/display_pkg.sv
/* pixel, address, buffer and video types shared by the frame store datapath and its control
   import into a module body, or use scoped names in a module header */
`default_nettype none

package display_pkg;

  localparam int PIXEL_ADDR_WIDTH = 18;                   // enough for 640 by 400 pixels
  localparam int WORD_ADDR_WIDTH = PIXEL_ADDR_WIDTH - 3;  // eight pixels per 32-bit word

  typedef logic [3:0] pixel_t;

  typedef enum logic {
    BUFFER_A,
    BUFFER_B
  } buffer_sel_e;

  // one pixel write from the bus side, valid for a single cycle
  typedef struct packed {
    logic                        enable;
    logic [PIXEL_ADDR_WIDTH-1:0] address;
    pixel_t                      data;
  } pixel_write_t;

  typedef struct packed {
    logic [PIXEL_ADDR_WIDTH-1:0] address;
    logic                        write_enable;
    logic                        clear_word;   // zeroes the whole word holding address
    pixel_t                      data;
  } ram_port_t;

  typedef struct packed {
    buffer_sel_e displayed_buffer;
    logic        swap_pending;
    logic        clearing;
  } buffer_status_t;

  typedef struct packed {
    logic                        valid;
    logic                        frame_start;  // first pixel of a frame
    logic [PIXEL_ADDR_WIDTH-1:0] index;
    pixel_t                      pixel;
  } video_t;

endpackage

`default_nettype wire

//--- verilog/apb_pkg.sv
/* APB request and response structs and the register offsets of the frame store slave */
`default_nettype none

package apb_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  typedef enum logic [7:0] {
    REG_CTRL       = 8'h00,  // bit 0 requests a buffer swap
    REG_STATUS     = 8'h04,
    REG_PIXEL_ADDR = 8'h08,
    REG_PIXEL_DATA = 8'h0C
  } apb_reg_e;

endpackage

`default_nettype wire

//--- verilog/pixel_ram.sv
/* one frame buffer of 32-bit words, eight 4-bit pixels per word
   a single port that writes a nibble or clears a word, with a registered nibble read */
`timescale 1ns/1ps
`default_nettype none

module pixel_ram (
  input  wire                    clock_in,
  input  wire                    reset_n_in,
  input  wire display_pkg::ram_port_t port,
  output display_pkg::pixel_t    read_data
);

  import display_pkg::*;

  logic [31:0]                mem [0:(1 << WORD_ADDR_WIDTH)-1];
  logic [WORD_ADDR_WIDTH-1:0] word_address;
  logic [2:0]                 nibble;

  assign word_address = port.address[PIXEL_ADDR_WIDTH-1:3];
  assign nibble       = port.address[2:0];  // pixel 0 sits in the low nibble

  always_ff @(posedge clock_in) begin
    if (port.clear_word) begin
      mem[word_address] <= '0;
    end else if (port.write_enable) begin
      mem[word_address][{nibble, 2'b00} +: 4] <= port.data;
    end
  end

  // read data follows the address by one cycle
  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      read_data <= '0;
    end else begin
      read_data <= mem[word_address][{nibble, 2'b00} +: 4];
    end
  end

endmodule

`default_nettype wire

//--- verilog/scan_counter.sv
/* walks the read address over the frame once per frame period
   and delays the video tags so they meet the pixel at the output register */
`timescale 1ns/1ps
`default_nettype none

module scan_counter #(
  parameter int FRAME_WIDTH  = 640,
  parameter int FRAME_HEIGHT = 400
) (
  input  wire                                      clock_in,
  input  wire                                      reset_n_in,
  output logic [display_pkg::PIXEL_ADDR_WIDTH-1:0] scan_address,
  output logic                                     frame_wrap,
  output display_pkg::video_t                      scan_tags
);

  import display_pkg::*;

  localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
  localparam logic [PIXEL_ADDR_WIDTH-1:0] LAST_ADDRESS = PIXEL_ADDR_WIDTH'(FRAME_PIXELS - 1);

  video_t tag_stage;  // first of the two tag delay stages

  assign frame_wrap = (scan_address == LAST_ADDRESS);

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      scan_address <= '0;
      tag_stage    <= '0;
      scan_tags    <= '0;
    end else begin
      scan_address <= frame_wrap ? '0 : scan_address + 1'b1;
      // the pixel field is filled in later from the front RAM
      tag_stage    <= '{valid:       1'b1,
                        frame_start: (scan_address == '0),
                        index:       scan_address,
                        pixel:       '0};
      scan_tags    <= tag_stage;
    end
  end

endmodule

`default_nettype wire

//--- verilog/buffer_control.sv
/* swap FSM, back buffer clear sequencer and RAM port steering for the two frame buffers
   also registers the front buffer pixel together with its tags as the video output */
`timescale 1ns/1ps
`default_nettype none

module buffer_control #(
  parameter int FRAME_WIDTH  = 640,
  parameter int FRAME_HEIGHT = 400
) (
  input  wire                                      clock_in,
  input  wire                                      reset_n_in,
  input  wire display_pkg::pixel_write_t           pixel_write,
  input  wire                                      swap_request,
  input  wire [display_pkg::PIXEL_ADDR_WIDTH-1:0]  scan_address,
  input  wire                                      frame_wrap,
  input  wire display_pkg::video_t                 scan_tags,
  output display_pkg::ram_port_t                   ram_a_port,
  output display_pkg::ram_port_t                   ram_b_port,
  input  wire display_pkg::pixel_t                 ram_a_data,
  input  wire display_pkg::pixel_t                 ram_b_data,
  output display_pkg::buffer_status_t              status,
  output display_pkg::video_t                      video
);

  import display_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    PENDING,
    CLEARING
  } state_e;

  localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
  localparam int CLEAR_WORDS  = FRAME_PIXELS / 8;
  localparam logic [WORD_ADDR_WIDTH-1:0] LAST_WORD = WORD_ADDR_WIDTH'(CLEAR_WORDS - 1);

  state_e                     state;
  buffer_sel_e                displayed;
  logic [WORD_ADDR_WIDTH-1:0] clear_count;
  buffer_sel_e                read_sel_q1;  // buffer chosen when the read port was registered
  buffer_sel_e                read_sel_q2;  // same, aligned with the RAM read data
  ram_port_t                  read_port;
  ram_port_t                  write_port;
  pixel_t                     front_data;

  assign status = '{displayed_buffer: displayed,
                    swap_pending:     (state == PENDING),
                    clearing:         (state == CLEARING)};

  // a swap waits for the last pixel of the frame so the next frame comes whole from one buffer
  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      state       <= IDLE;
      displayed   <= BUFFER_A;
      clear_count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (swap_request) state <= PENDING;
        end
        PENDING: begin
          if (frame_wrap) begin
            state       <= CLEARING;
            displayed   <= (displayed == BUFFER_A) ? BUFFER_B : BUFFER_A;
            clear_count <= '0;
          end
        end
        CLEARING: begin
          clear_count <= clear_count + 1'b1;  // one word per cycle
          if (clear_count == LAST_WORD) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    read_port = '{address: scan_address, write_enable: 1'b0, clear_word: 1'b0, data: '0};
    if (state == CLEARING) begin
      // pixel writes are held off by the bus slave for the whole clear
      write_port = '{address:      {clear_count, 3'b000},
                     write_enable: 1'b0,
                     clear_word:   1'b1,
                     data:         '0};
    end else begin
      write_port = '{address:      pixel_write.address,
                     write_enable: pixel_write.enable,
                     clear_word:   1'b0,
                     data:         pixel_write.data};
    end
  end

  assign front_data = (read_sel_q2 == BUFFER_A) ? ram_a_data : ram_b_data;

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      ram_a_port  <= '0;
      ram_b_port  <= '0;
      read_sel_q1 <= BUFFER_A;
      read_sel_q2 <= BUFFER_A;
      video       <= '0;
    end else begin
      ram_a_port  <= (displayed == BUFFER_A) ? read_port : write_port;
      ram_b_port  <= (displayed == BUFFER_A) ? write_port : read_port;
      read_sel_q1 <= displayed;
      read_sel_q2 <= read_sel_q1;
      video       <= '{valid:       scan_tags.valid,
                       frame_start: scan_tags.frame_start,
                       index:       scan_tags.index,
                       pixel:       front_data};
    end
  end

endmodule

`default_nettype wire

//--- verilog/apb_display_regs.sv
/* APB slave for the frame store, with control, status, pixel address and pixel data registers
   data writes go to the back buffer one pixel at a time with an auto-incrementing address */
`timescale 1ns/1ps
`default_nettype none

module apb_display_regs #(
  parameter int FRAME_WIDTH  = 640,
  parameter int FRAME_HEIGHT = 400
) (
  input  wire                              clock_in,
  input  wire                              reset_n_in,
  input  wire apb_pkg::apb_req_t           apb_req,
  output apb_pkg::apb_rsp_t                apb_rsp,
  input  wire display_pkg::buffer_status_t status,
  output display_pkg::pixel_write_t        pixel_write,
  output logic                             swap_request
);

  import apb_pkg::*;
  import display_pkg::*;

  localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
  localparam logic [PIXEL_ADDR_WIDTH-1:0] LAST_PIXEL = PIXEL_ADDR_WIDTH'(FRAME_PIXELS - 1);

  apb_reg_e                    reg_sel;
  logic                        access;
  logic                        mapped;
  logic                        held;
  logic                        write_done;
  logic [PIXEL_ADDR_WIDTH-1:0] pixel_address;

  assign reg_sel = apb_reg_e'(apb_req.paddr);
  assign access  = apb_req.psel && apb_req.penable;
  assign mapped  = reg_sel inside {REG_CTRL, REG_STATUS, REG_PIXEL_ADDR, REG_PIXEL_DATA};

  // swaps and pixel data wait until the back buffer has been cleared
  assign held = status.clearing && (reg_sel == REG_CTRL || reg_sel == REG_PIXEL_DATA);

  assign write_done = access && !held && apb_req.pwrite;

  always_comb begin
    apb_rsp.pready  = access && !held;
    apb_rsp.pslverr = access && !mapped;
    case (reg_sel)
      REG_STATUS: begin
        apb_rsp.prdata = {29'd0, status.clearing, status.swap_pending, status.displayed_buffer};
      end
      REG_PIXEL_ADDR: apb_rsp.prdata = 32'(pixel_address);
      default:        apb_rsp.prdata = '0;  // control and data registers are write only
    endcase
  end

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      pixel_address <= '0;
      pixel_write   <= '0;
      swap_request  <= 1'b0;
    end else begin
      pixel_write.enable <= 1'b0;  // both outputs are single cycle pulses
      swap_request       <= 1'b0;
      if (write_done) begin
        case (reg_sel)
          REG_CTRL:       swap_request  <= apb_req.pwdata[0];
          REG_PIXEL_ADDR: pixel_address <= apb_req.pwdata[PIXEL_ADDR_WIDTH-1:0];
          REG_PIXEL_DATA: begin
            pixel_write   <= '{enable: 1'b1, address: pixel_address, data: apb_req.pwdata[3:0]};
            pixel_address <= (pixel_address == LAST_PIXEL) ? '0 : pixel_address + 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/display_top.sv
/* double-buffered pixel frame store, written over APB and read out as a pixel stream
   the frame size parameters are passed down to every block that counts pixels */
`timescale 1ns/1ps
`default_nettype none

module display_top #(
  parameter int FRAME_WIDTH  = 640,
  parameter int FRAME_HEIGHT = 400
) (
  input  wire                    clock_in,
  input  wire                    reset_n_in,
  input  wire apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t      apb_rsp,
  output display_pkg::video_t    video
);

  import display_pkg::*;

  pixel_write_t                pixel_write;
  logic                        swap_request;
  buffer_status_t              status;
  logic [PIXEL_ADDR_WIDTH-1:0] scan_address;
  logic                        frame_wrap;
  video_t                      scan_tags;
  ram_port_t                   ram_a_port;
  ram_port_t                   ram_b_port;
  pixel_t                      ram_a_data;
  pixel_t                      ram_b_data;

  apb_display_regs #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) regs (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .status       (status),
    .pixel_write  (pixel_write),
    .swap_request (swap_request)
  );

  buffer_control #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) control (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .pixel_write  (pixel_write),
    .swap_request (swap_request),
    .scan_address (scan_address),
    .frame_wrap   (frame_wrap),
    .scan_tags    (scan_tags),
    .ram_a_port   (ram_a_port),
    .ram_b_port   (ram_b_port),
    .ram_a_data   (ram_a_data),
    .ram_b_data   (ram_b_data),
    .status       (status),
    .video        (video)
  );

  scan_counter #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) scan (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .scan_address (scan_address),
    .frame_wrap   (frame_wrap),
    .scan_tags    (scan_tags)
  );

  pixel_ram ram_a (
    .clock_in   (clock_in),
    .reset_n_in (reset_n_in),
    .port       (ram_a_port),
    .read_data  (ram_a_data)
  );

  pixel_ram ram_b (
    .clock_in   (clock_in),
    .reset_n_in (reset_n_in),
    .port       (ram_b_port),
    .read_data  (ram_b_data)
  );

endmodule

`default_nettype wire

//--- bench/display_asserts.sv
/* concurrent checks on the buffer control, bound into every buffer_control instance */
`timescale 1ns/1ps
`default_nettype none

module display_asserts #(
  parameter int FRAME_WIDTH  = 640,
  parameter int FRAME_HEIGHT = 400
) (
  input wire                              clock_in,
  input wire                              reset_n_in,
  input wire display_pkg::ram_port_t      ram_a_port,
  input wire display_pkg::ram_port_t      ram_b_port,
  input wire display_pkg::buffer_sel_e    read_sel,  // buffer that got the read port
  input wire                              frame_wrap,
  input wire display_pkg::buffer_status_t status
);

  import display_pkg::*;

  localparam int CLEAR_WORDS = FRAME_WIDTH * FRAME_HEIGHT / 8;

  int clear_cycles;  // clearing cycles already seen in the current clear

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      clear_cycles <= 0;
    end else begin
      clear_cycles <= status.clearing ? clear_cycles + 1 : 0;
    end
  end

  front_a_read_only: assert property (@(posedge clock_in) disable iff (!reset_n_in)
    (read_sel == BUFFER_A) |-> !(ram_a_port.write_enable || ram_a_port.clear_word))
    else $error("write or clear enabled on front buffer A");

  front_b_read_only: assert property (@(posedge clock_in) disable iff (!reset_n_in)
    (read_sel == BUFFER_B) |-> !(ram_b_port.write_enable || ram_b_port.clear_word))
    else $error("write or clear enabled on front buffer B");

  clear_length: assert property (@(posedge clock_in) disable iff (!reset_n_in)
    status.clearing |-> (clear_cycles < CLEAR_WORDS))
    else $error("clearing lasted longer than one word per cycle over the frame");

  // a clear only starts where a pending swap meets the frame boundary
  clear_after_frame_wrap: assert property (@(posedge clock_in) disable iff (!reset_n_in)
    $rose(status.clearing) |-> ($past(status.swap_pending) && $past(frame_wrap)))
    else $error("clearing started without a pending swap at the frame boundary");

endmodule

bind buffer_control display_asserts #(
  .FRAME_WIDTH  (FRAME_WIDTH),
  .FRAME_HEIGHT (FRAME_HEIGHT)
) asserts (
  .clock_in   (clock_in),
  .reset_n_in (reset_n_in),
  .ram_a_port (ram_a_port),
  .ram_b_port (ram_b_port),
  .read_sel   (read_sel_q1),
  .frame_wrap (frame_wrap),
  .status     (status)
);

`default_nettype wire

//--- bench/display_tb.sv
/* directed testbench for the double-buffered frame store on a 16 by 8 frame
   drives APB on the falling edge and checks the video stream against a pixel model */
`timescale 1ns/1ps
`default_nettype none

module display_tb;

  import display_pkg::*;
  import apb_pkg::*;

  localparam int FRAME_WIDTH    = 16;
  localparam int FRAME_HEIGHT   = 8;
  localparam int FRAME_PIXELS   = FRAME_WIDTH * FRAME_HEIGHT;
  localparam int TIMEOUT_CYCLES = 40 * FRAME_PIXELS;  // about three times the longest run
  localparam int QUARTER_PERIOD = 25;

  logic     clock_in;
  logic     reset_n_in;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  video_t   video;
  int       seed = 51590;
  int       cycle_count = 0;
  pixel_t   model [FRAME_PIXELS];     // expected contents of the next displayed frame
  pixel_t   captured [FRAME_PIXELS];

  display_top #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) DUT (
    .clock_in   (clock_in),
    .reset_n_in (reset_n_in),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .video      (video)
  );

  initial clock_in = 1'b0;
  always #50 clock_in = ~clock_in;

  always @(posedge clock_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // setup phase, then access phase until pready, sampled a quarter period after the drive
  task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr, output int waits);
    waits = 0;
    @(negedge clock_in);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clock_in);
    apb_req.penable = 1'b1;
    #(QUARTER_PERIOD);
    while (!apb_rsp.pready) begin
      waits++;
      @(negedge clock_in);
      #(QUARTER_PERIOD);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clock_in);  // the access completed on the edge just passed
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                           output logic slverr, output int waits);
    logic [31:0] unused_rdata;
    apb_access(1'b1, addr, wdata, unused_rdata, slverr, waits);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic slverr);
    int waits;
    apb_access(1'b0, addr, 32'd0, rdata, slverr, waits);
    check_equal(32'(waits), 32'd0, "wait states on a read");
  endtask

  task automatic read_status(output logic [31:0] status_word);
    logic err;
    apb_read(REG_STATUS, status_word, err);
    check_equal(32'(err), 32'd0, "pslverr on status read");
  endtask

  task automatic wait_status_bit(input int bit_index, input logic value);
    logic [31:0] status_word;
    read_status(status_word);
    while (status_word[bit_index] !== value) read_status(status_word);
  endtask

  task automatic request_swap;
    logic err;
    int   waits;
    apb_write(REG_CTRL, 32'd1, err, waits);
    check_equal(32'(err), 32'd0, "pslverr on swap request");
  endtask

  // random pixels from start onward, wrapping at the frame end like the address register
  task automatic fill_pixels(input int start, input int count);
    logic [31:0] rnd;
    logic        err;
    int          waits;
    int          address;
    apb_write(REG_PIXEL_ADDR, start, err, waits);
    for (int i = 0; i < count; i++) begin
      rnd = $random(seed);
      address = (start + i) % FRAME_PIXELS;
      model[address] = rnd[3:0];
      apb_write(REG_PIXEL_DATA, {28'd0, rnd[3:0]}, err, waits);
      check_equal(32'(err), 32'd0, "pslverr on pixel write");
    end
  endtask

  task automatic wait_frame_start;
    @(negedge clock_in);
    while (!(video.valid && video.frame_start)) @(negedge clock_in);
  endtask

  task automatic capture_frame;
    wait_frame_start();
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      check_equal(32'(video.valid), 32'd1, "video valid inside a frame");
      check_equal(32'(video.index), i, "video pixel index");
      captured[i] = video.pixel;
      @(negedge clock_in);
    end
  endtask

  task automatic compare_frame(input string what);
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      check_equal(32'(captured[i]), 32'(model[i]), $sformatf("%s, pixel %0d", what, i));
    end
  endtask

  task automatic after_reset_checks;
    logic [31:0] rdata;
    logic        err;
    int          waits;
    check_equal(32'(apb_rsp.pready), 32'd0, "pready idle after reset");
    check_equal(32'(apb_rsp.pslverr), 32'd0, "pslverr idle after reset");
    check_equal(32'(video.valid), 32'd0, "video valid after reset");
    apb_read(REG_STATUS, rdata, err);
    check_equal(rdata, 32'd0, "status after reset");
    check_equal(32'(err), 32'd0, "pslverr on status read after reset");
    apb_read(8'h10, rdata, err);
    check_equal(32'(err), 32'd1, "pslverr on unmapped read");
    apb_write(8'h1C, 32'd5, err, waits);
    check_equal(32'(err), 32'd1, "pslverr on unmapped write");
  endtask

  task automatic fill_and_swap;
    logic [31:0] status_word;
    fill_pixels(0, FRAME_PIXELS);
    wait_frame_start();  // early in the frame, so the request is still pending when read
    request_swap();
    read_status(status_word);
    check_equal(status_word, 32'h2, "status while swap pending");
  endtask

  task automatic write_held_while_clearing;
    logic [31:0] status_word;
    logic        err;
    int          waits;
    wait_status_bit(2, 1'b1);
    apb_write(REG_PIXEL_DATA, 32'd0, err, waits);  // zero keeps the cleared buffer all zeros
    check_equal(32'(waits > 0), 32'd1, "pixel write held during clear");
    read_status(status_word);
    check_equal(status_word, 32'h1, "status once the held write completed");
  endtask

  task automatic first_swapped_frame;
    logic [31:0] status_word;
    capture_frame();
    compare_frame("frame after first swap");
    read_status(status_word);
    check_equal(status_word, 32'h1, "status shows buffer B");
  endtask

  task automatic pixel_address_readback;
    logic [31:0] rdata;
    logic        err;
    int          waits;
    // address 0, then a full frame of data writes plus the held one
    apb_read(REG_PIXEL_ADDR, rdata, err);
    check_equal(rdata, (FRAME_PIXELS + 1) % FRAME_PIXELS, "pixel address after data writes");
    apb_write(REG_PIXEL_ADDR, 32'd100, err, waits);
    apb_read(REG_PIXEL_ADDR, rdata, err);
    check_equal(rdata, 32'd100, "pixel address written and read back");
  endtask

  task automatic cleared_frame_and_partial;
    for (int i = 0; i < FRAME_PIXELS; i++) model[i] = 4'h0;
    request_swap();
    wait_status_bit(0, 1'b0);
    capture_frame();
    compare_frame("cleared buffer A");
    // buffer B was cleared after the last swap so only these pixels are set
    fill_pixels(37, 50);
    request_swap();
    wait_status_bit(0, 1'b1);
    capture_frame();
    compare_frame("partial frame in buffer B");
  endtask

  initial begin
    apb_req    = '0;
    reset_n_in = 1'b0;
    repeat (16) @(negedge clock_in);
    reset_n_in = 1'b1;
    after_reset_checks();
    fill_and_swap();
    write_held_while_clearing();
    first_swapped_frame();
    pixel_address_readback();
    cleared_frame_and_partial();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
verilog/display_pkg.sv
verilog/apb_pkg.sv
verilog/pixel_ram.sv
verilog/scan_counter.sv
verilog/buffer_control.sv
verilog/apb_display_regs.sv
verilog/display_top.sv
bench/display_asserts.sv
bench/display_tb.sv

//--- Makefile
# Verilator build and run of the frame store testbench

VERILATOR ?= verilator
TOP       ?= display_tb
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
